// File: hpsdr_proto_pkg.sv
// Protocol constants and stream types shared by the downstream Ethernet pipeline
package hpsdr_proto_pkg;

  // UDP port carrying PC to card traffic
  localparam logic [15:0] ds_port = 16'd1024;

  localparam logic [7:0] preamble0 = 8'hef;
  localparam logic [7:0] preamble1 = 8'hfe;

  // Packet type byte
  localparam logic [7:0] type_data      = 8'h01;
  localparam logic [7:0] type_discovery = 8'h02;
  localparam logic [7:0] type_runstop   = 8'h04;

  localparam logic [7:0] endpoint_data = 8'h02;
  localparam logic [7:0] sync_byte     = 8'h7f;

  localparam int frames_per_packet = 2;
  localparam int groups_per_frame  = 63;
  localparam int group_width       = $clog2(groups_per_frame);
  localparam int frame_width       = $clog2(frames_per_packet);
  localparam int watchdog_width    = 10;

  typedef struct packed {
    logic [15:0] port;
    logic        valid;
    logic [7:0]  data;
    logic        unreachable;
  } eth_rx_t;

  // Last marks the fourth byte of a pair
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       last;
  } ds_byte_t;

  typedef struct packed {
    logic [15:0] left;
    logic [15:0] right;
  } lr_pair_t;

  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_pair_t;

  typedef struct packed {
    logic        valid;
    logic        resprqst;
    logic [5:0]  addr;
    logic        ptt;
    logic [31:0] data;
  } cmd_t;

endpackage

// File: hpsdr_ctrl_pkg.sv
// Host side register map, APB request/response types and status word layout
package hpsdr_ctrl_pkg;

  localparam int num_cmd_regs   = 16;
  localparam int reg_idx_width  = $clog2(num_cmd_regs);
  localparam int apb_addr_width = 8;

  // Byte addresses, registers are word aligned from zero
  localparam logic [apb_addr_width-1:0] reg_window_end = apb_addr_width'(num_cmd_regs * 4);
  localparam logic [apb_addr_width-1:0] status_offset  = 8'h40;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [31:0]               pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Run sits in bit 0
  typedef struct packed {
    logic [5:0]  pad;
    logic [15:0] cmd_count;
    logic [5:0]  last_addr;
    logic        resprqst;
    logic        ptt;
    logic        wide_spectrum;
    logic        run;
  } status_t;

endpackage

// File: ds_frame_parser.sv
// Downstream packet parser: run/discovery control, command capture, sample byte routing, watchdog
`timescale 1ns/100ps

module ds_frame_parser (
  input  logic                      clk,
  input  logic                      arst_n,
  input  hpsdr_proto_pkg::eth_rx_t  eth,
  input  logic                      watchdog_up,
  output logic                      discovery,
  output logic                      run,
  output logic                      wide_spectrum,
  output logic                      ptt,
  output hpsdr_proto_pkg::cmd_t     cmd,
  output hpsdr_proto_pkg::ds_byte_t lr_byte,
  output hpsdr_proto_pkg::ds_byte_t iq_byte
);

  typedef enum logic [3:0] {
    st_idle,
    st_pre1,
    st_type,
    st_runstop,
    st_endpoint,
    st_seq,
    st_sync,
    st_ctrl,
    st_cmd,
    st_group,
    st_skip
  } state_t;

  state_t state;

  logic [2:0]                                   byte_cnt;
  logic [hpsdr_proto_pkg::group_width-1:0]      group_cnt;
  logic [hpsdr_proto_pkg::frame_width-1:0]      frame_cnt;
  logic [hpsdr_proto_pkg::watchdog_width-1:0]   wd_cnt;

  logic        beat;
  logic        on_port;
  logic        seq_end;
  logic        frame_end;
  logic        packet_end;

  logic        cmd_valid;
  logic        resprqst_q;
  logic [5:0]  addr_q;
  logic        ptt_q;
  logic [31:0] data_q;

  logic        lr_valid;
  logic        iq_valid;
  logic        byte_last;
  logic [7:0]  byte_data;

  assign beat    = eth.valid & ~eth.unreachable;
  assign on_port = (eth.port == hpsdr_proto_pkg::ds_port);
  assign seq_end = beat && (state == st_seq) && (byte_cnt == 3'd3);

  // A group is eight bytes, L1 L0 R1 R0 I1 I0 Q1 Q0
  assign frame_end = (byte_cnt == 3'd7) &&
      (group_cnt == hpsdr_proto_pkg::group_width'(hpsdr_proto_pkg::groups_per_frame - 1));
  assign packet_end = frame_end &&
      (frame_cnt == hpsdr_proto_pkg::frame_width'(hpsdr_proto_pkg::frames_per_packet - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= st_idle;
      byte_cnt      <= '0;
      group_cnt     <= '0;
      frame_cnt     <= '0;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
      discovery     <= 1'b0;
      cmd_valid     <= 1'b0;
      resprqst_q    <= 1'b0;
      addr_q        <= '0;
      ptt_q         <= 1'b0;
      lr_valid      <= 1'b0;
      iq_valid      <= 1'b0;
      byte_last     <= 1'b0;
    end else begin
      discovery <= 1'b0;
      cmd_valid <= 1'b0;
      lr_valid  <= 1'b0;
      iq_valid  <= 1'b0;
      if (eth.unreachable) begin
        state         <= st_idle;
        run           <= 1'b0;
        wide_spectrum <= 1'b0;
      end else if (!eth.valid) begin
        state <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            // Only the first byte of a burst can open a packet
            if (on_port && eth.data == hpsdr_proto_pkg::preamble0) state <= st_pre1;
            else state <= st_skip;
          end
          st_pre1: begin
            if (on_port && eth.data == hpsdr_proto_pkg::preamble1) state <= st_type;
            else state <= st_skip;
          end
          st_type: begin
            case (eth.data)
              hpsdr_proto_pkg::type_data:    state <= st_endpoint;
              hpsdr_proto_pkg::type_runstop: state <= st_runstop;
              hpsdr_proto_pkg::type_discovery: begin
                discovery <= 1'b1;
                state     <= st_skip;
              end
              default: state <= st_skip;
            endcase
          end
          st_runstop: begin
            run           <= eth.data[0];
            wide_spectrum <= eth.data[1];
            state         <= st_skip;
          end
          st_endpoint: begin
            byte_cnt <= '0;
            if (eth.data == hpsdr_proto_pkg::endpoint_data) state <= st_seq;
            else state <= st_skip;
          end
          st_seq: begin
            // Sequence number is not used
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == 3'd3) begin
              byte_cnt  <= '0;
              frame_cnt <= '0;
              state     <= st_sync;
            end
          end
          st_sync: begin
            byte_cnt <= byte_cnt + 3'd1;
            if (eth.data != hpsdr_proto_pkg::sync_byte) begin
              state <= st_skip;
            end else if (byte_cnt == 3'd2) begin
              byte_cnt <= '0;
              state    <= st_ctrl;
            end
          end
          st_ctrl: begin
            resprqst_q <= eth.data[7];
            addr_q     <= eth.data[6:1];
            ptt_q      <= eth.data[0];
            state      <= st_cmd;
          end
          st_cmd: begin
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == 3'd3) begin
              cmd_valid <= 1'b1;
              byte_cnt  <= '0;
              group_cnt <= '0;
              state     <= st_group;
            end
          end
          st_group: begin
            lr_valid  <= ~byte_cnt[2];
            iq_valid  <= byte_cnt[2] & ptt_q;
            byte_last <= (byte_cnt[1:0] == 2'd3);
            byte_cnt  <= byte_cnt + 3'd1;
            if (byte_cnt == 3'd7) group_cnt <= group_cnt + 1'b1;
            if (frame_end) begin
              group_cnt <= '0;
              frame_cnt <= frame_cnt + 1'b1;
              state     <= packet_end ? st_idle : st_sync;
            end
          end
          default: state <= st_skip;
        endcase
      end
      if (&wd_cnt) run <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    byte_data <= eth.data;
    if (beat && state == st_cmd) data_q <= {data_q[23:0], eth.data};
  end

  // Cleared by each data packet, stops transmit when the host goes quiet
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wd_cnt <= '0;
    end else if (!run || seq_end) begin
      wd_cnt <= '0;
    end else if (watchdog_up) begin
      wd_cnt <= wd_cnt + 1'b1;
    end
  end

  assign ptt     = ptt_q;
  assign cmd     = '{valid: cmd_valid, resprqst: resprqst_q, addr: addr_q,
                     ptt: ptt_q, data: data_q};
  assign lr_byte = '{valid: lr_valid, data: byte_data, last: byte_last};
  assign iq_byte = '{valid: iq_valid, data: byte_data, last: byte_last};

  cmd_strobe_a: assert property (@(posedge clk) disable iff (!arst_n)
    cmd.valid |=> !cmd.valid);

  route_excl_a: assert property (@(posedge clk) disable iff (!arst_n)
    !(lr_byte.valid && iq_byte.valid));

endmodule

// File: sample_assembler.sv
// Packs four routed bytes, most significant first, into one sample pair of a chosen type
`timescale 1ns/100ps

module sample_assembler #(
  parameter type payload_t = hpsdr_proto_pkg::lr_pair_t
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  hpsdr_proto_pkg::ds_byte_t in_byte,
  output payload_t                  pair,
  output logic                      pair_valid
);

  localparam int pair_width = $bits(payload_t);

  logic [pair_width-1:0] shift_q;
  logic [1:0]            idx;

  // Byte index within the pair
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idx        <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= 1'b0;
      if (in_byte.valid) begin
        if (in_byte.last) begin
          // Short pair is dropped
          pair_valid <= (idx == 2'd3);
          idx        <= '0;
        end else begin
          idx <= idx + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_byte.valid) shift_q <= {shift_q[pair_width-9:0], in_byte.data};
  end

  assign pair = payload_t'(shift_q);

  pair_size_a: assert property (@(posedge clk) disable iff (!arst_n)
    pair_width == 32);

endmodule

// File: cmd_reg_bank.sv
// Command register storage and status word, read by the host over APB
`timescale 1ns/100ps

module cmd_reg_bank (
  input  logic                     clk,
  input  logic                     arst_n,
  input  hpsdr_proto_pkg::cmd_t    cmd,
  input  logic                     run,
  input  logic                     wide_spectrum,
  input  logic                     ptt,
  input  hpsdr_ctrl_pkg::apb_req_t apb_req,
  output hpsdr_ctrl_pkg::apb_rsp_t apb_rsp
);

  logic [31:0] regs [hpsdr_ctrl_pkg::num_cmd_regs];

  logic [15:0] cmd_count;
  logic [5:0]  last_addr;
  logic        last_resprqst;

  hpsdr_ctrl_pkg::status_t status;

  logic        access;
  logic        in_window;
  logic        is_status;
  logic [31:0] rd_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < hpsdr_ctrl_pkg::num_cmd_regs; i++) begin
        regs[i] <= '0;
      end
      cmd_count     <= '0;
      last_addr     <= '0;
      last_resprqst <= 1'b0;
    end else if (cmd.valid) begin
      // Addresses past the bank are counted but not stored
      if (cmd.addr < hpsdr_ctrl_pkg::num_cmd_regs) begin
        regs[cmd.addr[hpsdr_ctrl_pkg::reg_idx_width-1:0]] <= cmd.data;
      end
      cmd_count     <= cmd_count + 16'd1;
      last_addr     <= cmd.addr;
      last_resprqst <= cmd.resprqst;
    end
  end

  assign status = '{pad: '0, cmd_count: cmd_count, last_addr: last_addr,
                    resprqst: last_resprqst, ptt: ptt,
                    wide_spectrum: wide_spectrum, run: run};

  assign access    = apb_req.psel & apb_req.penable;
  assign in_window = (apb_req.paddr < hpsdr_ctrl_pkg::reg_window_end);
  assign is_status = (apb_req.paddr == hpsdr_ctrl_pkg::status_offset);

  always_comb begin
    rd_data = '0;
    if (in_window) begin
      rd_data = regs[apb_req.paddr[2 +: hpsdr_ctrl_pkg::reg_idx_width]];
    end else if (is_status) begin
      rd_data = status;
    end
  end

  // No wait states, the bank is read only
  assign apb_rsp.pready  = access;
  assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
  assign apb_rsp.pslverr = access & (apb_req.pwrite | ~(in_window | is_status));

  apb_enable_a: assert property (@(posedge clk) disable iff (!arst_n)
    apb_req.penable |-> apb_req.psel);

endmodule

// File: hpsdr_ds_top.sv
// Downstream top level joining the frame parser, the LR and IQ assemblers and the register bank
`timescale 1ns/100ps

module hpsdr_ds_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  hpsdr_proto_pkg::eth_rx_t eth,
  input  logic                     watchdog_up,
  output logic                     discovery,
  output logic                     run,
  output logic                     wide_spectrum,
  output hpsdr_proto_pkg::lr_pair_t lr_pair,
  output logic                     lr_valid,
  output hpsdr_proto_pkg::iq_pair_t iq_pair,
  output logic                     iq_valid,
  input  hpsdr_ctrl_pkg::apb_req_t apb_req,
  output hpsdr_ctrl_pkg::apb_rsp_t apb_rsp
);

  hpsdr_proto_pkg::ds_byte_t lr_byte;
  hpsdr_proto_pkg::ds_byte_t iq_byte;
  hpsdr_proto_pkg::cmd_t     cmd;
  logic                      ptt;

  ds_frame_parser u_parser (
    .clk           (clk),
    .arst_n        (arst_n),
    .eth           (eth),
    .watchdog_up   (watchdog_up),
    .discovery     (discovery),
    .run           (run),
    .wide_spectrum (wide_spectrum),
    .ptt           (ptt),
    .cmd           (cmd),
    .lr_byte       (lr_byte),
    .iq_byte       (iq_byte)
  );

  sample_assembler #(.payload_t(hpsdr_proto_pkg::lr_pair_t)) u_lr_asm (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_byte    (lr_byte),
    .pair       (lr_pair),
    .pair_valid (lr_valid)
  );

  sample_assembler #(.payload_t(hpsdr_proto_pkg::iq_pair_t)) u_iq_asm (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_byte    (iq_byte),
    .pair       (iq_pair),
    .pair_valid (iq_valid)
  );

  cmd_reg_bank u_regs (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd           (cmd),
    .run           (run),
    .wide_spectrum (wide_spectrum),
    .ptt           (ptt),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp)
  );

endmodule

// File: hpsdr_ds_tb.sv
// Self-checking testbench for the downstream top level, run as the simulation top
`timescale 1ns/100ps

module hpsdr_ds_tb;

  logic                       clk;
  logic                       arst_n;
  hpsdr_proto_pkg::eth_rx_t   eth;
  logic                       watchdog_up;
  logic                       discovery;
  logic                       run;
  logic                       wide_spectrum;
  hpsdr_proto_pkg::lr_pair_t  lr_pair;
  logic                       lr_valid;
  hpsdr_proto_pkg::iq_pair_t  iq_pair;
  logic                       iq_valid;
  hpsdr_ctrl_pkg::apb_req_t   apb_req;
  hpsdr_ctrl_pkg::apb_rsp_t   apb_rsp;

  logic [15:0] lfsr;
  int          value_errors;
  int          other_errors;
  int          disc_count;
  logic [31:0] lr_q[$];
  logic [31:0] iq_q[$];
  logic [31:0] reg_model [16];
  logic [15:0] exp_count;
  logic [5:0]  exp_addr;
  logic        exp_resprqst;
  logic        exp_ptt;

  hpsdr_ds_top DUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .eth           (eth),
    .watchdog_up   (watchdog_up),
    .discovery     (discovery),
    .run           (run),
    .wide_spectrum (wide_spectrum),
    .lr_pair       (lr_pair),
    .lr_valid      (lr_valid),
    .iq_pair       (iq_pair),
    .iq_valid      (iq_valid),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hang guard for the whole run
  initial begin
    #200000;
    $display("** Error: simulation timed out");
    $display("Finished with errors");
    $finish;
  end

  // Galois LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // Expected status word, run in bit 0
  function automatic logic [31:0] status_ref(input logic run_b, input logic ws_b,
      input logic ptt_b, input logic rq_b, input logic [5:0] addr_b,
      input logic [15:0] count_b);
    return {6'd0, count_b, addr_b, rq_b, ptt_b, ws_b, run_b};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
      input logic [31:0] act);
    value_errors++;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("** Error: %s", what);
  endtask

  task automatic send_byte(input logic [15:0] port, input logic [7:0] data);
    @(negedge clk);
    eth = '{port: port, valid: 1'b1, data: data, unreachable: 1'b0};
  endtask

  task automatic end_packet();
    @(negedge clk);
    eth.valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic send_runstop(input logic [15:0] port, input logic [7:0] pre1,
      input logic [7:0] value);
    send_byte(port, hpsdr_proto_pkg::preamble0);
    send_byte(port, pre1);
    send_byte(port, hpsdr_proto_pkg::type_runstop);
    send_byte(port, value);
    end_packet();
  endtask

  // Frame 1 gets a broken third sync byte when bad_sync is set
  task automatic send_data_packet(input logic bad_sync);
    logic [15:0] p;
    logic [7:0]  ctrl;
    logic [31:0] word;
    logic [15:0] l;
    logic [15:0] r;
    logic [15:0] i;
    logic [15:0] q;
    logic        good;
    p = hpsdr_proto_pkg::ds_port;
    send_byte(p, hpsdr_proto_pkg::preamble0);
    send_byte(p, hpsdr_proto_pkg::preamble1);
    send_byte(p, hpsdr_proto_pkg::type_data);
    send_byte(p, hpsdr_proto_pkg::endpoint_data);
    for (int k = 0; k < 4; k++) send_byte(p, 8'(rand_bits(8)));
    for (int f = 0; f < hpsdr_proto_pkg::frames_per_packet; f++) begin
      good = !(bad_sync && f == 1);
      for (int k = 0; k < 3; k++) begin
        send_byte(p, (!good && k == 2) ? 8'h00 : hpsdr_proto_pkg::sync_byte);
      end
      // Address below 32 so that about half the commands land in the bank
      ctrl = 8'(rand_bits(8));
      ctrl[6] = 1'b0;
      word = rand_bits(32);
      send_byte(p, ctrl);
      for (int k = 3; k >= 0; k--) send_byte(p, word[8*k +: 8]);
      if (good) begin
        exp_count++;
        exp_addr = ctrl[6:1];
        exp_resprqst = ctrl[7];
        exp_ptt = ctrl[0];
        if (ctrl[6:1] < 16) reg_model[ctrl[4:1]] = word;
      end
      for (int g = 0; g < hpsdr_proto_pkg::groups_per_frame; g++) begin
        l = 16'(rand_bits(16));
        r = 16'(rand_bits(16));
        i = 16'(rand_bits(16));
        q = 16'(rand_bits(16));
        if (good) begin
          lr_q.push_back({l, r});
          if (ctrl[0]) iq_q.push_back({i, q});
        end
        send_byte(p, l[15:8]);
        send_byte(p, l[7:0]);
        send_byte(p, r[15:8]);
        send_byte(p, r[7:0]);
        send_byte(p, i[15:8]);
        send_byte(p, i[7:0]);
        send_byte(p, q[15:8]);
        send_byte(p, q[7:0]);
      end
    end
    end_packet();
  endtask

  task automatic wait_run(input logic level, input string what);
    int cnt;
    cnt = 0;
    while (run !== level && cnt < 32) begin
      @(negedge clk);
      cnt++;
    end
    if (run !== level) report_failure(what);
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr,
      output logic [31:0] rdata, output logic err);
    int cnt;
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: 32'h5a5a_0f0f};
    @(negedge clk);
    apb_req.penable = 1'b1;
    cnt = 0;
    @(posedge clk);
    while (!apb_rsp.pready && cnt < 16) begin
      @(posedge clk);
      cnt++;
    end
    if (!apb_rsp.pready) report_failure("APB access never got pready");
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic check_status(input string name, input logic exp_run, input logic exp_ws);
    logic [31:0] rd;
    logic        err;
    logic [31:0] exp;
    apb_access(1'b0, hpsdr_ctrl_pkg::status_offset, rd, err);
    exp = status_ref(exp_run, exp_ws, exp_ptt, exp_resprqst, exp_addr, exp_count);
    if (rd !== exp) report_mismatch(name, exp, rd);
    if (err !== 1'b0) report_failure("status read returned pslverr");
  endtask

  always @(negedge clk) begin
    if (discovery === 1'b1) disc_count++;
  end

  // Pair comparators
  always @(negedge clk) begin
    if (lr_valid === 1'b1) begin
      if (lr_q.size() == 0) report_failure("LR pair arrived with none expected");
      else if (lr_pair !== lr_q[0]) report_mismatch("lr pair", lr_q.pop_front(), lr_pair);
      else void'(lr_q.pop_front());
    end
  end

  always @(negedge clk) begin
    if (iq_valid === 1'b1) begin
      if (iq_q.size() == 0) report_failure("IQ pair arrived with none expected");
      else if (iq_pair !== iq_q[0]) report_mismatch("iq pair", iq_q.pop_front(), iq_pair);
      else void'(iq_q.pop_front());
    end
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    int          cnt;
    lfsr = 16'd24565;
    value_errors = 0;
    other_errors = 0;
    disc_count = 0;
    exp_count = '0;
    exp_addr = '0;
    exp_resprqst = 1'b0;
    exp_ptt = 1'b0;
    for (int k = 0; k < 16; k++) reg_model[k] = '0;
    arst_n = 1'b0;
    eth = '0;
    watchdog_up = 1'b0;
    apb_req = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Run/stop, then packets that must be ignored
    send_runstop(hpsdr_proto_pkg::ds_port, hpsdr_proto_pkg::preamble1, 8'h03);
    wait_run(1'b1, "run did not rise after run/stop packet");
    if (wide_spectrum !== 1'b1)
      report_mismatch("runstop wide_spectrum", 1, 32'(wide_spectrum));
    send_runstop(16'd1025, hpsdr_proto_pkg::preamble1, 8'h00);
    send_runstop(hpsdr_proto_pkg::ds_port, 8'hff, 8'h00);
    if (run !== 1'b1) report_mismatch("ignored packet run", 1, 32'(run));
    if (wide_spectrum !== 1'b1)
      report_mismatch("ignored packet wide_spectrum", 1, 32'(wide_spectrum));
    send_runstop(hpsdr_proto_pkg::ds_port, hpsdr_proto_pkg::preamble1, 8'h01);
    if (run !== 1'b1) report_mismatch("runstop 01 run", 1, 32'(run));
    if (wide_spectrum !== 1'b0)
      report_mismatch("runstop 01 wide_spectrum", 0, 32'(wide_spectrum));

    // Discovery
    send_byte(hpsdr_proto_pkg::ds_port, hpsdr_proto_pkg::preamble0);
    send_byte(hpsdr_proto_pkg::ds_port, hpsdr_proto_pkg::preamble1);
    send_byte(hpsdr_proto_pkg::ds_port, hpsdr_proto_pkg::type_discovery);
    end_packet();
    cnt = 0;
    while (disc_count == 0 && cnt < 32) begin
      @(negedge clk);
      cnt++;
    end
    repeat (4) @(negedge clk);
    if (disc_count != 1) report_mismatch("discovery pulses", 1, disc_count);

    // Data packets, one with a broken frame
    repeat (4) send_data_packet(1'b0);
    send_data_packet(1'b1);
    send_data_packet(1'b0);
    cnt = 0;
    while ((lr_q.size() != 0 || iq_q.size() != 0) && cnt < 64) begin
      @(negedge clk);
      cnt++;
    end
    if (lr_q.size() != 0 || iq_q.size() != 0) report_failure("expected pairs never arrived");

    for (int k = 0; k < 16; k++) begin
      apb_access(1'b0, 8'(k * 4), rd, err);
      if (rd !== reg_model[k]) report_mismatch($sformatf("cmd reg %0d", k), reg_model[k], rd);
      if (err !== 1'b0) report_failure("register read returned pslverr");
    end
    check_status("status with run", 1'b1, 1'b0);
    apb_access(1'b0, 8'h44, rd, err);
    if (rd !== '0) report_mismatch("out of range read data", 0, rd);
    if (err !== 1'b1) report_mismatch("out of range read pslverr", 1, 32'(err));
    apb_access(1'b1, 8'h00, rd, err);
    if (err !== 1'b1) report_mismatch("apb write pslverr", 1, 32'(err));

    // Watchdog, run must survive 1022 ticks and drop on the next
    repeat (1022) begin
      @(negedge clk);
      watchdog_up = 1'b1;
    end
    @(negedge clk);
    if (run !== 1'b1) report_mismatch("watchdog early clear", 1, 32'(run));
    @(negedge clk);
    watchdog_up = 1'b0;
    wait_run(1'b0, "watchdog did not clear run");
    check_status("status after watchdog", 1'b0, 1'b0);

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: hpsdr_ds_top.f
hpsdr_proto_pkg.sv
hpsdr_ctrl_pkg.sv
ds_frame_parser.sv
sample_assembler.sv
cmd_reg_bank.sv
hpsdr_ds_top.sv
hpsdr_ds_tb.sv

// File: Bender.yml
package:
  name: hpsdr_ds

dependencies: {}

sources:
  - hpsdr_proto_pkg.sv
  - hpsdr_ctrl_pkg.sv
  - ds_frame_parser.sv
  - sample_assembler.sv
  - cmd_reg_bank.sv
  - hpsdr_ds_top.sv

  - target: test
    files:
      - hpsdr_ds_tb.sv
